/* dv/lsu_wb_tb.sv */
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_wb_tb
	import wb_bus_pkg::*;
	import lsu_pkg::*;
();

	localparam int max_cycles = 10000;
	localparam int max_busy = 25;

	logic wb_clk_i;
	logic reset_i;
	logic req_i;
	wb_adr_t addr_i;
	access_size_t size_i;
	logic we_i;
	logic signed_i;
	wb_data_t wdata_i;
	wb_data_t rdata_o;
	logic busy_o;
	logic misalign_o;
	logic cfg_we_i;
	logic cfg_addr_i;
	logic [3:0] cfg_wdata_i;

	wb_data_t shadow [0:`LSU_SRAM_WORDS-1];
	int pool[$];
	int cycle_count = 0;
	int busy_len = 0;
	int mis_pulses = 0;
	logic req_q = 1'b0;
	logic quiet;
	logic load_chk;
	logic mis_chk;
	wb_data_t exp_rdata;

	lsu_wb_top i_dut (.*);

	always #20 wb_clk_i = ~wb_clk_i;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1, "run stopped on first error");
	endtask

	always @(posedge wb_clk_i) begin
		cycle_count <= cycle_count + 1;
		req_q <= req_i;
		busy_len <= busy_o ? busy_len + 1 : 0;
		if (req_i && !req_q) begin
			mis_pulses <= 0; // new request starts a fresh count.
		end else if (misalign_o) begin
			mis_pulses <= mis_pulses + 1;
		end
	end

	always @(posedge wb_clk_i) begin
		if (cycle_count >= max_cycles) begin
			fail_run($sformatf("Timeout: run did not finish within %0d cycles", max_cycles));
		end
	end

	a_reset_idle: assert property (@(posedge wb_clk_i) disable iff (reset_i)
		quiet |-> !busy_o && !misalign_o && rdata_o == 32'hffff_ffff)
		else fail_run("outputs left their reset values while the core was idle");

	a_busy_needs_req: assert property (@(posedge wb_clk_i) disable iff (reset_i)
		!req_i |-> !busy_o)
		else fail_run("busy_o was high without a request");

	a_load_data: assert property (@(posedge wb_clk_i) disable iff (reset_i)
		$fell(busy_o) && load_chk |-> rdata_o == exp_rdata)
		else fail_run($sformatf("Mismatch at %0t: load from 0x%h returned 0x%h, expected 0x%h",
			$time, $sampled(addr_i), $sampled(rdata_o), $sampled(exp_rdata)));

	a_busy_bounded: assert property (@(posedge wb_clk_i) disable iff (reset_i)
		busy_o |-> busy_len < max_busy)
		else fail_run("an access stayed busy for too many cycles");

	a_mis_no_busy: assert property (@(posedge wb_clk_i) disable iff (reset_i)
		mis_chk && req_i |-> !busy_o)
		else fail_run("busy_o rose for a misaligned request");

	a_mis_expected: assert property (@(posedge wb_clk_i) disable iff (reset_i)
		misalign_o |-> mis_chk)
		else fail_run("misalign_o pulsed for an aligned request");

	a_mis_once: assert property (@(posedge wb_clk_i) disable iff (reset_i)
		$fell(req_i) && mis_chk |-> mis_pulses == 1)
		else fail_run($sformatf("Mismatch at %0t: misalign_o pulsed %0d times, expected 1",
			$time, $sampled(mis_pulses)));

	function automatic wb_data_t merge_store(input wb_data_t old, input logic [1:0] lo,
			input access_size_t size, input wb_data_t data);
		wb_data_t res;
		res = old;
		case (size)
			size_byte: res[8*lo +: 8] = data[7:0];
			size_half: res[16*lo[1] +: 16] = data[15:0];
			default: res = data;
		endcase
		return res;
	endfunction

	function automatic wb_data_t load_value(input wb_data_t word, input logic [1:0] lo,
			input access_size_t size, input logic sgn);
		logic [7:0] b;
		logic [15:0] h;
		b = word[8*lo +: 8];
		h = word[16*lo[1] +: 16];
		case (size)
			size_byte: return sgn ? {{24{b[7]}}, b} : {24'd0, b};
			size_half: return sgn ? {{16{h[15]}}, h} : {16'd0, h};
			default: return word;
		endcase
	endfunction

	function automatic access_size_t pick_size();
		case ($urandom % 3)
			0: return size_byte;
			1: return size_half;
			default: return size_word;
		endcase
	endfunction

	task automatic wait_done();
		logic seen_busy;
		logic done;
		seen_busy = 1'b0;
		done = 1'b0;
		while (!done) begin
			@(negedge wb_clk_i);
			if (busy_o) begin
				seen_busy = 1'b1;
			end else if (seen_busy) begin
				done = 1'b1;
			end
		end
	endtask

	task automatic run_access(input wb_adr_t addr, input access_size_t size, input logic we,
			input logic sgn, input wb_data_t data);
		int idx;
		logic in_range;
		wb_data_t word;
		idx = int'(addr >> 2);
		in_range = idx < `LSU_SRAM_WORDS;
		word = in_range ? shadow[idx] : 32'hffff_ffff; // errored loads read all ones.
		@(posedge wb_clk_i);
		req_i <= 1'b1;
		addr_i <= addr;
		size_i <= size;
		we_i <= we;
		signed_i <= sgn;
		wdata_i <= data;
		load_chk <= !we;
		mis_chk <= 1'b0;
		exp_rdata <= load_value(word, addr[1:0], size, sgn);
		wait_done();
		@(posedge wb_clk_i);
		req_i <= 1'b0;
		if (we && in_range) begin
			shadow[idx] = merge_store(shadow[idx], addr[1:0], size, data);
		end
	endtask

	task automatic run_misaligned(input wb_adr_t addr, input access_size_t size,
			input logic we, input wb_data_t data);
		@(posedge wb_clk_i);
		req_i <= 1'b1;
		addr_i <= addr;
		size_i <= size;
		we_i <= we;
		wdata_i <= data;
		load_chk <= 1'b0;
		mis_chk <= 1'b1;
		repeat (4) @(posedge wb_clk_i);
		req_i <= 1'b0;
	endtask

	task automatic random_access();
		int idx;
		int offs;
		access_size_t size;
		idx = pool[$urandom % pool.size()];
		size = pick_size();
		offs = $urandom % 4;
		if (size == size_half) begin
			offs = offs & 2;
		end else if (size == size_word) begin
			offs = 0;
		end
		run_access(wb_adr_t'(idx * 4 + offs), size, 1'($urandom), 1'($urandom), $urandom);
	endtask

	task automatic write_cfg(input logic addr, input logic [3:0] data);
		@(posedge wb_clk_i);
		cfg_we_i <= 1'b1;
		cfg_addr_i <= addr;
		cfg_wdata_i <= data;
		@(posedge wb_clk_i);
		cfg_we_i <= 1'b0;
	endtask

	initial begin
		int idx;
		wb_adr_t far;
		wb_clk_i = 1'b0;
		reset_i = 1'b1;
		req_i = 1'b0;
		addr_i = '0;
		size_i = size_word;
		we_i = 1'b0;
		signed_i = 1'b0;
		wdata_i = '0;
		cfg_we_i = 1'b0;
		cfg_addr_i = 1'b0;
		cfg_wdata_i = 4'd0;
		quiet = 1'b1;
		load_chk = 1'b0;
		mis_chk = 1'b0;
		exp_rdata = '1;
		void'($urandom(85));
		repeat (8) @(posedge wb_clk_i);
		reset_i <= 1'b0;
		repeat (10) @(posedge wb_clk_i);
		quiet <= 1'b0;

		pool.push_back(0);
		pool.push_back(`LSU_SRAM_WORDS - 1);
		for (int i = 0; i < 32; i++) begin
			pool.push_back($urandom % `LSU_SRAM_WORDS);
		end
		foreach (pool[i]) begin
			run_access(wb_adr_t'(pool[i] * 4), size_word, 1'b1, 1'b0, $urandom);
		end
		foreach (pool[i]) begin
			run_access(wb_adr_t'(pool[i] * 4), size_word, 1'b0, 1'b0, 32'd0);
		end

		repeat (80) random_access();

		for (int s = 0; s < 6; s++) begin
			write_cfg(1'b0, (s == 0) ? 4'd15 : 4'($urandom));
			write_cfg(1'b1, (s == 0) ? 4'd1 : 4'($urandom)); // only bit 0 sticks.
			repeat (15) random_access();
		end

		for (int i = 0; i < 8; i++) begin
			idx = pool[$urandom % pool.size()];
			far = wb_adr_t'(idx * 4 + (1 + $urandom % 15) * `LSU_SRAM_WORDS * 4);
			run_access(far, size_word, 1'b1, 1'b0, $urandom);
			run_access(far, size_word, 1'b0, 1'b0, 32'd0);
			run_access(wb_adr_t'(idx * 4), size_word, 1'b0, 1'b0, 32'd0); // low alias.
		end

		for (int i = 0; i < 8; i++) begin
			idx = pool[$urandom % pool.size()];
			if (i % 2 == 0) begin
				run_misaligned(wb_adr_t'(idx * 4 + 1 + 2 * ($urandom % 2)), size_half,
					1'($urandom), $urandom);
			end else begin
				run_misaligned(wb_adr_t'(idx * 4 + 1 + $urandom % 3), size_word,
					1'($urandom), $urandom);
			end
			run_access(wb_adr_t'(idx * 4), size_word, 1'b0, 1'b0, 32'd0);
		end

		repeat (4) @(posedge wb_clk_i);
		$display("All checks passed");
		$finish;
	end

endmodule

/* run_sim.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module lsu_wb_tb -o lsu_wb_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/lsu_wb_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation failed with status $status"
	exit "$status"
fi

exit 0

/* sim.f */
+incdir+source
source/wb_bus_pkg.sv
source/lsu_pkg.sv
source/lsu_align.sv
source/core_wb_master.sv
source/wb_sram.sv
source/wb_timing_regs.sv
source/lsu_wb_top.sv
dv/lsu_wb_tb.sv

/* source/core_wb_master.sv */
`timescale 1ns/1ps

module core_wb_master
	import wb_bus_pkg::*;
(
	input logic wb_clk_i,
	input logic reset_i,
	input logic en_i,
	input logic we_i,
	input wb_adr_t adr_i,
	input wb_sel_t sel_i,
	input wb_data_t wdata_i,
	output wb_data_t rdata_o,
	output logic busy_o,
	output logic wb_cyc_o,
	output logic wb_stb_o,
	output logic wb_we_o,
	output wb_sel_t wb_sel_o,
	output wb_adr_t wb_adr_o,
	output wb_data_t wb_dat_o,
	input logic wb_ack_i,
	input logic wb_stall_i,
	input logic wb_err_i,
	input wb_data_t wb_dat_i
);

	typedef enum logic [1:0] {
		st_idle = 2'd0,
		st_write = 2'd1,
		st_read = 2'd2,
		st_end = 2'd3
	} state_t;

	state_t state_q;
	logic stb_q;
	wb_data_t rdata_q;

	always_ff @(posedge wb_clk_i) begin
		if (reset_i || (wb_err_i && state_q != st_idle)) begin
			state_q <= st_idle;
			stb_q <= 1'b0;
			rdata_q <= '1; // aborted loads read back as all ones.
		end else begin
			case (state_q)
				st_idle: begin
					rdata_q <= '1;
					if (en_i) begin
						state_q <= we_i ? st_write : st_read;
						stb_q <= 1'b1;
					end
				end
				st_write, st_read: begin
					// strobe stays up until the slave takes it.
					if (wb_stb_o && !wb_stall_i) begin
						stb_q <= 1'b0;
					end
					if (!en_i) begin
						state_q <= st_idle;
						stb_q <= 1'b0;
						rdata_q <= '1;
					end else if (wb_ack_i) begin
						state_q <= st_end;
						if (state_q == st_read) begin
							rdata_q <= wb_dat_i;
						end
					end
				end
				st_end: begin
					state_q <= st_idle;
				end
				default: begin
					state_q <= st_idle;
					stb_q <= 1'b0;
				end
			endcase
		end
	end

	assign wb_cyc_o = (state_q != st_idle) && en_i;
	assign wb_stb_o = stb_q && en_i;
	assign wb_we_o = state_q == st_write;
	assign wb_sel_o = sel_i;
	assign wb_adr_o = adr_i;
	assign wb_dat_o = wdata_i;

	assign rdata_o = rdata_q;
	assign busy_o = wb_cyc_o;

	a_stb_in_cyc: assert property (@(posedge wb_clk_i) disable iff (reset_i)
		wb_stb_o |-> wb_cyc_o);

	// the slave only answers a cycle we opened.
	a_no_ack_idle: assert property (@(posedge wb_clk_i) disable iff (reset_i)
		wb_ack_i |-> state_q != st_idle);

endmodule

/* source/lsu_align.sv */
`timescale 1ns/1ps

module lsu_align
	import wb_bus_pkg::*;
	import lsu_pkg::*;
(
	input logic wb_clk_i,
	input logic reset_i,
	input logic req_i,
	input wb_adr_t addr_i,
	input access_size_t size_i,
	input logic we_i,
	input logic signed_i,
	input wb_data_t wdata_i,
	input wb_data_t bus_rdata_i,
	output logic bus_en_o,
	output wb_sel_t bus_sel_o,
	output wb_data_t bus_wdata_o,
	output wb_data_t rdata_o,
	output logic misalign_o
);

	logic misaligned;
	logic mis_req;
	logic mis_held_q;
	data_lanes_u st_lanes;
	data_lanes_u ld_lanes;
	logic [7:0] ld_byte;
	logic [15:0] ld_half;

	always_comb begin
		case (size_i)
			size_half: misaligned = addr_i[0];
			size_word: misaligned = addr_i[1:0] != 2'd0;
			default: misaligned = 1'b0;
		endcase
	end

	assign mis_req = req_i && misaligned;
	assign bus_en_o = req_i && !misaligned;

	// replicate the low lane(s) so any selected lane carries the data.
	always_comb begin
		st_lanes = wdata_i;
		bus_sel_o = 4'b1111;
		case (size_i)
			size_byte: begin
				st_lanes.b = {4{wdata_i[7:0]}};
				bus_sel_o = 4'b0001 << addr_i[1:0];
			end
			size_half: begin
				st_lanes.h = {2{wdata_i[15:0]}};
				bus_sel_o = addr_i[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				st_lanes = wdata_i;
				bus_sel_o = 4'b1111;
			end
		endcase
	end

	// stores only need the placed word when we_i is set.
	assign bus_wdata_o = we_i ? wb_data_t'(st_lanes) : '0;

	assign ld_lanes = bus_rdata_i;
	assign ld_byte = ld_lanes.b[addr_i[1:0]];
	assign ld_half = ld_lanes.h[addr_i[1]];

	always_comb begin
		case (size_i)
			size_byte: rdata_o = {{24{signed_i & ld_byte[7]}}, ld_byte};
			size_half: rdata_o = {{16{signed_i & ld_half[15]}}, ld_half};
			default: rdata_o = bus_rdata_i;
		endcase
	end

	// one pulse per held misaligned request.
	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			mis_held_q <= 1'b0;
			misalign_o <= 1'b0;
		end else begin
			mis_held_q <= mis_req;
			misalign_o <= mis_req && !mis_held_q;
		end
	end

	a_sel_nonzero: assert property (@(posedge wb_clk_i) disable iff (reset_i)
		bus_en_o |-> bus_sel_o != 4'd0);

endmodule

/* source/lsu_cfg.svh */
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// byte address width, core side and bus side.
`define LSU_ADDR_WIDTH 16

// sram size in 32-bit words; word indexes from here up are out of range.
`define LSU_SRAM_WORDS 1024

// timing register values after reset.
`define LSU_WAIT_RESET 4'd0
`define LSU_STALL_RESET 1'b0

`endif

/* source/lsu_pkg.sv */
package lsu_pkg;

	typedef enum logic [1:0] {
		size_byte = 2'd0,
		size_half = 2'd1,
		size_word = 2'd2
	} access_size_t;

	// the same data word seen as byte lanes or as halfword lanes.
	typedef union packed {
		logic [3:0][7:0] b;
		logic [1:0][15:0] h;
	} data_lanes_u;

endpackage

/* source/lsu_wb_top.sv */
`timescale 1ns/1ps

module lsu_wb_top
	import wb_bus_pkg::*;
	import lsu_pkg::*;
(
	input logic wb_clk_i,
	input logic reset_i,
	input logic req_i,
	input wb_adr_t addr_i,
	input access_size_t size_i,
	input logic we_i,
	input logic signed_i,
	input wb_data_t wdata_i,
	output wb_data_t rdata_o,
	output logic busy_o,
	output logic misalign_o,
	input logic cfg_we_i,
	input logic cfg_addr_i,
	input logic [3:0] cfg_wdata_i
);

	logic bus_en;
	wb_sel_t bus_sel;
	wb_data_t bus_wdata;
	wb_data_t bus_rdata;

	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	wb_sel_t wb_sel;
	wb_adr_t wb_adr;
	wb_data_t wb_dat_w;
	logic wb_ack;
	logic wb_stall;
	logic wb_err;
	wb_data_t wb_dat_r;

	logic [3:0] wait_cycles;
	logic stall_first;

	lsu_align i_align (
		.wb_clk_i(wb_clk_i),
		.reset_i(reset_i),
		.req_i(req_i),
		.addr_i(addr_i),
		.size_i(size_i),
		.we_i(we_i),
		.signed_i(signed_i),
		.wdata_i(wdata_i),
		.bus_rdata_i(bus_rdata),
		.bus_en_o(bus_en),
		.bus_sel_o(bus_sel),
		.bus_wdata_o(bus_wdata),
		.rdata_o(rdata_o),
		.misalign_o(misalign_o)
	);

	core_wb_master i_master (
		.wb_clk_i(wb_clk_i),
		.reset_i(reset_i),
		.en_i(bus_en),
		.we_i(we_i),
		.adr_i(addr_i),
		.sel_i(bus_sel),
		.wdata_i(bus_wdata),
		.rdata_o(bus_rdata),
		.busy_o(busy_o),
		.wb_cyc_o(wb_cyc),
		.wb_stb_o(wb_stb),
		.wb_we_o(wb_we),
		.wb_sel_o(wb_sel),
		.wb_adr_o(wb_adr),
		.wb_dat_o(wb_dat_w),
		.wb_ack_i(wb_ack),
		.wb_stall_i(wb_stall),
		.wb_err_i(wb_err),
		.wb_dat_i(wb_dat_r)
	);

	wb_sram i_sram (
		.wb_clk_i(wb_clk_i),
		.reset_i(reset_i),
		.wb_cyc_i(wb_cyc),
		.wb_stb_i(wb_stb),
		.wb_we_i(wb_we),
		.wb_sel_i(wb_sel),
		.wb_adr_i(wb_adr),
		.wb_dat_i(wb_dat_w),
		.wb_ack_o(wb_ack),
		.wb_stall_o(wb_stall),
		.wb_err_o(wb_err),
		.wb_dat_o(wb_dat_r),
		.wait_cycles_i(wait_cycles),
		.stall_first_i(stall_first)
	);

	wb_timing_regs i_timing (
		.wb_clk_i(wb_clk_i),
		.reset_i(reset_i),
		.cfg_we_i(cfg_we_i),
		.cfg_addr_i(cfg_addr_i),
		.cfg_wdata_i(cfg_wdata_i),
		.wait_cycles_o(wait_cycles),
		.stall_first_o(stall_first)
	);

endmodule

/* source/wb_bus_pkg.sv */
`include "lsu_cfg.svh"

package wb_bus_pkg;

	// byte address as seen on the bus.
	typedef logic [`LSU_ADDR_WIDTH-1:0] wb_adr_t;

	typedef logic [31:0] wb_data_t;

	// one select bit per byte lane.
	typedef logic [3:0] wb_sel_t;

endpackage

/* source/wb_sram.sv */
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module wb_sram
	import wb_bus_pkg::*;
(
	input logic wb_clk_i,
	input logic reset_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_we_i,
	input wb_sel_t wb_sel_i,
	input wb_adr_t wb_adr_i,
	input wb_data_t wb_dat_i,
	output logic wb_ack_o,
	output logic wb_stall_o,
	output logic wb_err_o,
	output wb_data_t wb_dat_o,
	input logic [3:0] wait_cycles_i,
	input logic stall_first_i
);

	localparam int idx_w = $clog2(`LSU_SRAM_WORDS);

	wb_data_t mem [0:`LSU_SRAM_WORDS-1];

	logic stall_done_q;
	logic pend_q;
	logic [3:0] cnt_q;
	logic we_q;
	wb_sel_t sel_q;
	wb_adr_t adr_q;
	wb_data_t dat_q;

	logic accept;
	logic fire;
	logic op_we;
	wb_sel_t op_sel;
	wb_adr_t op_adr;
	wb_data_t op_dat;
	logic [`LSU_ADDR_WIDTH-3:0] op_word;
	logic in_range;

	// stall only the first strobe cycle of each bus cycle.
	assign wb_stall_o = stall_first_i && wb_stb_i && !stall_done_q;

	assign accept = wb_cyc_i && wb_stb_i && !wb_stall_o && !pend_q;
	assign fire = (accept && wait_cycles_i == 4'd0) ||
		(pend_q && wb_cyc_i && cnt_q == 4'd0);

	// zero wait states act on the live bus request.
	assign op_we = pend_q ? we_q : wb_we_i;
	assign op_sel = pend_q ? sel_q : wb_sel_i;
	assign op_adr = pend_q ? adr_q : wb_adr_i;
	assign op_dat = pend_q ? dat_q : wb_dat_i;
	assign op_word = op_adr[`LSU_ADDR_WIDTH-1:2];
	assign in_range = op_word < `LSU_SRAM_WORDS;

	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			stall_done_q <= 1'b0;
			pend_q <= 1'b0;
			cnt_q <= 4'd0;
			wb_ack_o <= 1'b0;
			wb_err_o <= 1'b0;
		end else begin
			stall_done_q <= wb_cyc_i && (stall_done_q || wb_stb_i);
			wb_ack_o <= fire && in_range;
			wb_err_o <= fire && !in_range;
			if (!wb_cyc_i || fire) begin
				pend_q <= 1'b0; // a dropped cycle cancels the response.
			end else if (accept) begin
				pend_q <= 1'b1;
				cnt_q <= wait_cycles_i - 4'd1;
			end else if (pend_q) begin
				cnt_q <= cnt_q - 4'd1;
			end
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (accept) begin
			we_q <= wb_we_i;
			sel_q <= wb_sel_i;
			adr_q <= wb_adr_i;
			dat_q <= wb_dat_i;
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (fire && in_range) begin
			if (op_we) begin
				for (int i = 0; i < 4; i++) begin
					if (op_sel[i]) begin
						mem[op_word[idx_w-1:0]][8*i +: 8] <= op_dat[8*i +: 8];
					end
				end
			end else begin
				wb_dat_o <= mem[op_word[idx_w-1:0]];
			end
		end
	end

	a_ack_err_excl: assert property (@(posedge wb_clk_i) disable iff (reset_i)
		!(wb_ack_o && wb_err_o));

endmodule

/* source/wb_timing_regs.sv */
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module wb_timing_regs (
	input logic wb_clk_i,
	input logic reset_i,
	input logic cfg_we_i,
	input logic cfg_addr_i,
	input logic [3:0] cfg_wdata_i,
	output logic [3:0] wait_cycles_o,
	output logic stall_first_o
);

	logic [3:0] wait_q;
	logic stall_q;

	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			wait_q <= `LSU_WAIT_RESET;
			stall_q <= `LSU_STALL_RESET;
		end else if (cfg_we_i) begin
			if (cfg_addr_i) begin
				stall_q <= cfg_wdata_i[0]; // upper bits ignored.
			end else begin
				wait_q <= cfg_wdata_i;
			end
		end
	end

	assign wait_cycles_o = wait_q;
	assign stall_first_o = stall_q;

endmodule
